/* common/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

   localparam int XLEN = 32;

   typedef logic [4:0] cnt_t;
   typedef logic [4:0] reg_addr_t;

   typedef struct packed {
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
   } rf_addr_t;

   // Major opcodes in instr[6:0]
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_OPIMM  = 7'b0010011;
   localparam logic [6:0] OP_OP     = 7'b0110011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_BEQ = 3'b000;
   localparam logic [2:0] F3_BNE = 3'b001;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_t;

   typedef struct packed {
      alu_op_t alu_op;
      logic    op_b_imm;
      logic    rd_op;
      logic    two_stage;
      logic    mem_op;
      logic    mem_we;
      logic    branch;
      logic    bne;
      logic    jal;
   } ctrl_t;

   typedef struct packed {
      cnt_t cnt;
      logic cnt_en;
      logic phase2;
      logic rd_en;
      logic pc_en;
   } seq_t;

endpackage

`default_nettype wire

/* common/bus_pkg.sv */
`default_nettype none

package bus_pkg;

   // One master request held steady from cyc until ack
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic        we;
      logic        cyc;
   } bus_req_t;

   typedef struct packed {
      logic [31:0] rdt;
      logic        ack;
   } bus_rsp_t;

endpackage

`default_nettype wire

/* core/core_state.sv */
`default_nettype none
`timescale 1ns/1ps

module core_state
   import rv_isa_pkg::*;
  (
   input wire        clk,
   input wire        i_reset,
   input wire ctrl_t i_ctrl,
   input wire        i_ibus_ack,
   input wire        i_dbus_ack,
   output logic      o_ibus_cyc,
   output logic      o_dbus_cyc,
   output seq_t      o_seq
   );

   typedef enum logic [1:0] {
      S_FETCH,
      S_PH1,
      S_MEM,
      S_PH2
   } state_t;

   state_t state;
   cnt_t   cnt;
   logic   in_ph1;
   logic   in_ph2;
   logic   last;

   assign in_ph1 = (state == S_PH1);
   assign in_ph2 = (state == S_PH2);
   assign last   = (cnt == 5'd31);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state      <= S_FETCH;
         cnt        <= '0;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
      end else begin
         // Wraps back to 0 after bit 31
         if (in_ph1 || in_ph2)
            cnt <= cnt + 5'd1;
         case (state)
            S_FETCH: begin
               if (i_ibus_ack) begin
                  o_ibus_cyc <= 1'b0;
                  state      <= S_PH1;
               end else begin
                  o_ibus_cyc <= 1'b1;
               end
            end
            S_PH1: begin
               if (last) begin
                  if (!i_ctrl.two_stage) begin
                     o_ibus_cyc <= 1'b1;
                     state      <= S_FETCH;
                  end else if (i_ctrl.mem_op) begin
                     o_dbus_cyc <= 1'b1;
                     state      <= S_MEM;
                  end else begin
                     state <= S_PH2;
                  end
               end
            end
            S_MEM: begin
               if (i_dbus_ack) begin
                  o_dbus_cyc <= 1'b0;
                  state      <= S_PH2;
               end
            end
            default: begin
               if (last) begin
                  o_ibus_cyc <= 1'b1;
                  state      <= S_FETCH;
               end
            end
         endcase
      end
   end

   // rd and PC are written in the last phase of the instruction
   always_comb begin
      o_seq.cnt    = cnt;
      o_seq.cnt_en = in_ph1 || in_ph2;
      o_seq.phase2 = in_ph2;
      o_seq.rd_en  = i_ctrl.rd_op && (i_ctrl.two_stage ? in_ph2 : in_ph1);
      o_seq.pc_en  = i_ctrl.two_stage ? in_ph2 : in_ph1;
   end

endmodule

`default_nettype wire

/* core/core_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module core_decode
   import rv_isa_pkg::*;
   import bus_pkg::*;
  (
   input wire           clk,
   input wire bus_rsp_t i_ibus_rsp,
   input wire seq_t     i_seq,
   output ctrl_t        o_ctrl,
   output rf_addr_t     o_rf_addr,
   output logic         o_imm_bit
   );

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic        funct7_b5;
   logic [31:0] rdt;
   logic [31:0] imm_fmt;
   logic [31:0] imm_q;

   assign rdt = i_ibus_rsp.rdt;

   always_comb begin
      case (rdt[6:0])
         OP_STORE:  imm_fmt = {{20{rdt[31]}}, rdt[31:25], rdt[11:7]};
         OP_BRANCH: imm_fmt = {{20{rdt[31]}}, rdt[7], rdt[30:25], rdt[11:8], 1'b0};
         OP_JAL:    imm_fmt = {{12{rdt[31]}}, rdt[19:12], rdt[20], rdt[30:21], 1'b0};
         OP_LUI:    imm_fmt = {rdt[31:12], 12'd0};
         default:   imm_fmt = {{20{rdt[31]}}, rdt[31:20]};
      endcase
   end

   // Rotates so a second phase sees the immediate again
   always_ff @(posedge clk) begin
      if (i_ibus_rsp.ack) begin
         opcode    <= rdt[6:0];
         funct3    <= rdt[14:12];
         funct7_b5 <= rdt[30];
         o_rf_addr <= '{rs1: rdt[19:15], rs2: rdt[24:20], rd: rdt[11:7]};
         imm_q     <= imm_fmt;
      end else if (i_seq.cnt_en) begin
         imm_q <= {imm_q[0], imm_q[31:1]};
      end
   end

   assign o_imm_bit = imm_q[0];

   always_comb begin
      // Anything unknown falls through as a no-op
      o_ctrl = '0;
      case (opcode)
         OP_LUI: begin
            o_ctrl.alu_op   = ALU_PASS_B;
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.rd_op    = 1'b1;
         end
         OP_OPIMM, OP_OP: begin
            o_ctrl.op_b_imm = (opcode == OP_OPIMM);
            o_ctrl.rd_op    = 1'b1;
            case (funct3)
               F3_ADD:  o_ctrl.alu_op = (opcode == OP_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
               F3_XOR:  o_ctrl.alu_op = ALU_XOR;
               F3_OR:   o_ctrl.alu_op = ALU_OR;
               F3_AND:  o_ctrl.alu_op = ALU_AND;
               default: o_ctrl.rd_op  = 1'b0;
            endcase
         end
         OP_LOAD, OP_STORE: begin
            o_ctrl.op_b_imm  = 1'b1;
            o_ctrl.rd_op     = (opcode == OP_LOAD);
            o_ctrl.two_stage = 1'b1;
            o_ctrl.mem_op    = 1'b1;
            o_ctrl.mem_we    = (opcode == OP_STORE);
         end
         OP_BRANCH: begin
            if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
               o_ctrl.two_stage = 1'b1;
               o_ctrl.branch    = 1'b1;
               o_ctrl.bne       = (funct3 == F3_BNE);
            end
         end
         OP_JAL: begin
            o_ctrl.rd_op = 1'b1;
            o_ctrl.jal   = 1'b1;
         end
         default: o_ctrl = '0;
      endcase
   end

endmodule

`default_nettype wire

/* core/serial_rf.sv */
`default_nettype none
`timescale 1ns/1ps

module serial_rf
   import rv_isa_pkg::*;
  (
   input wire           clk,
   input wire seq_t     i_seq,
   input wire rf_addr_t i_rf_addr,
   input wire           i_rd_bit,
   output logic         o_rs1_bit,
   output logic         o_rs2_bit
   );

   logic [XLEN-1:0] regs [32];

   // Writes one bit of rd per cycle and never x0
   always_ff @(posedge clk) begin
      if (i_seq.rd_en && (i_rf_addr.rd != 5'd0))
         regs[i_rf_addr.rd][i_seq.cnt] <= i_rd_bit;
   end

   // Bit cnt is read before it is overwritten in the same cycle
   assign o_rs1_bit = (i_rf_addr.rs1 == 5'd0) ? 1'b0 : regs[i_rf_addr.rs1][i_seq.cnt];
   assign o_rs2_bit = (i_rf_addr.rs2 == 5'd0) ? 1'b0 : regs[i_rf_addr.rs2][i_seq.cnt];

endmodule

`default_nettype wire

/* core/core_datapath.sv */
`default_nettype none
`timescale 1ns/1ps

module core_datapath
   import rv_isa_pkg::*;
   import bus_pkg::*;
  #(parameter logic [31:0] RESET_PC = 32'd0)
  (
   input wire           clk,
   input wire           i_reset,
   input wire seq_t     i_seq,
   input wire ctrl_t    i_ctrl,
   input wire           i_imm_bit,
   input wire           i_rs1_bit,
   input wire           i_rs2_bit,
   input wire bus_rsp_t i_dbus_rsp,
   output logic         o_rd_bit,
   output logic [31:0]  o_ibus_adr,
   output logic [31:0]  o_dbus_adr,
   output logic [31:0]  o_dbus_dat,
   output logic         o_dbus_we
   );

   logic [XLEN-1:0] pc_q;
   logic [XLEN-1:0] adr_q;
   logic [XLEN-1:0] dat_q;
   logic            cnt0;
   logic            ph1;
   logic            op_b;
   logic            sub;
   logic            b_eff;
   logic            alu_cin;
   logic            alu_carry_q;
   logic            alu_sum;
   logic            alu_bit;
   logic            eq_q;
   logic            taken;
   logic            four_bit;
   logic            pc_off;
   logic            pc_cin;
   logic            pc_carry_q;
   logic            pc_next;
   logic            link_cin;
   logic            link_carry_q;
   logic            link_bit;

   assign cnt0 = (i_seq.cnt == 5'd0);
   assign ph1  = i_seq.cnt_en && !i_seq.phase2;
   assign op_b = i_ctrl.op_b_imm ? i_imm_bit : i_rs2_bit;
   assign sub  = (i_ctrl.alu_op == ALU_SUB);

   // rs1 + ~b + 1 for SUB
   assign b_eff   = op_b ^ sub;
   assign alu_cin = cnt0 ? sub : alu_carry_q;
   assign alu_sum = i_rs1_bit ^ b_eff ^ alu_cin;

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_AND:    alu_bit = i_rs1_bit & op_b;
         ALU_OR:     alu_bit = i_rs1_bit | op_b;
         ALU_XOR:    alu_bit = i_rs1_bit ^ op_b;
         ALU_PASS_B: alu_bit = op_b;
         default:    alu_bit = alu_sum;
      endcase
   end

   // PC adder and the PC+4 link adder both walk pc_q[0]
   assign taken    = i_ctrl.branch && (eq_q ^ i_ctrl.bne);
   assign four_bit = (i_seq.cnt == 5'd2);
   assign pc_off   = (i_ctrl.jal || taken) ? i_imm_bit : four_bit;
   assign pc_cin   = !cnt0 && pc_carry_q;
   assign pc_next  = pc_q[0] ^ pc_off ^ pc_cin;
   assign link_cin = !cnt0 && link_carry_q;
   assign link_bit = pc_q[0] ^ four_bit ^ link_cin;

   always_ff @(posedge clk) begin
      if (i_seq.cnt_en) begin
         alu_carry_q  <= (i_rs1_bit & b_eff) | (alu_cin & (i_rs1_bit ^ b_eff));
         pc_carry_q   <= (pc_q[0] & pc_off) | (pc_cin & (pc_q[0] ^ pc_off));
         link_carry_q <= (pc_q[0] & four_bit) | (link_cin & (pc_q[0] ^ four_bit));
      end
      if (ph1)
         eq_q <= (cnt0 || eq_q) && !(i_rs1_bit ^ i_rs2_bit);
      if (ph1 && i_ctrl.mem_op)
         adr_q <= {alu_bit, adr_q[XLEN-1:1]};
      // Store data shifts in during phase 1, load data shifts out in phase 2
      if (i_dbus_rsp.ack && !i_ctrl.mem_we)
         dat_q <= i_dbus_rsp.rdt;
      else if (i_seq.cnt_en && i_ctrl.mem_op)
         dat_q <= {i_seq.phase2 ? dat_q[0] : i_rs2_bit, dat_q[XLEN-1:1]};
   end

   always_ff @(posedge clk) begin
      if (i_reset)
         pc_q <= RESET_PC;
      else if (i_seq.pc_en)
         pc_q <= {pc_next, pc_q[XLEN-1:1]};
   end

   always_comb begin
      if (i_seq.phase2)
         o_rd_bit = dat_q[0];
      else if (i_ctrl.jal)
         o_rd_bit = link_bit;
      else
         o_rd_bit = alu_bit;
   end

   assign o_ibus_adr = pc_q;
   assign o_dbus_adr = adr_q;
   assign o_dbus_dat = dat_q;
   assign o_dbus_we  = i_ctrl.mem_we;

endmodule

`default_nettype wire

/* logic/bus_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

module bus_arbiter
   import bus_pkg::*;
  (
   input wire           clk,
   input wire           i_reset,
   input wire bus_req_t i_ibus_req,
   input wire bus_req_t i_dbus_req,
   output bus_rsp_t     o_ibus_rsp,
   output bus_rsp_t     o_dbus_rsp,
   output bus_req_t     o_mem_req,
   input wire bus_rsp_t i_mem_rsp
   );

   logic busy;
   logic grant_d;

   // Data port first when both ask
   always_ff @(posedge clk) begin
      if (i_reset) begin
         busy    <= 1'b0;
         grant_d <= 1'b0;
      end else if (busy) begin
         if (i_mem_rsp.ack)
            busy <= 1'b0;
      end else if (i_dbus_req.cyc || i_ibus_req.cyc) begin
         busy    <= 1'b1;
         grant_d <= i_dbus_req.cyc;
      end
   end

   always_comb begin
      o_mem_req     = grant_d ? i_dbus_req : i_ibus_req;
      o_mem_req.cyc = busy && (grant_d ? i_dbus_req.cyc : i_ibus_req.cyc);
   end

   assign o_ibus_rsp = '{rdt: i_mem_rsp.rdt, ack: i_mem_rsp.ack && busy && !grant_d};
   assign o_dbus_rsp = '{rdt: i_mem_rsp.rdt, ack: i_mem_rsp.ack && busy && grant_d};

endmodule

`default_nettype wire

/* logic/cpu_top.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu_top
   import rv_isa_pkg::*;
   import bus_pkg::*;
  #(parameter logic [31:0] RESET_PC = 32'd0)
  (
   input wire           clk,
   input wire           i_reset,
   output bus_req_t     o_mem_req,
   input wire bus_rsp_t i_mem_rsp
   );

   ctrl_t       ctrl;
   seq_t        seq;
   rf_addr_t    rf_addr;
   logic        imm_bit;
   logic        rs1_bit;
   logic        rs2_bit;
   logic        rd_bit;
   logic        ibus_cyc;
   logic        dbus_cyc;
   logic        dbus_we;
   logic [31:0] ibus_adr;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   bus_req_t    ibus_req;
   bus_req_t    dbus_req;
   bus_rsp_t    ibus_rsp;
   bus_rsp_t    dbus_rsp;

   // Instruction port never writes
   assign ibus_req = '{adr: ibus_adr, dat: 32'd0, we: 1'b0, cyc: ibus_cyc};
   assign dbus_req = '{adr: dbus_adr, dat: dbus_dat, we: dbus_we, cyc: dbus_cyc};

   core_state core_state_inst
     (.clk        (clk),
      .i_reset    (i_reset),
      .i_ctrl     (ctrl),
      .i_ibus_ack (ibus_rsp.ack),
      .i_dbus_ack (dbus_rsp.ack),
      .o_ibus_cyc (ibus_cyc),
      .o_dbus_cyc (dbus_cyc),
      .o_seq      (seq));

   core_decode core_decode_inst
     (.clk        (clk),
      .i_ibus_rsp (ibus_rsp),
      .i_seq      (seq),
      .o_ctrl     (ctrl),
      .o_rf_addr  (rf_addr),
      .o_imm_bit  (imm_bit));

   serial_rf serial_rf_inst
     (.clk       (clk),
      .i_seq     (seq),
      .i_rf_addr (rf_addr),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit));

   core_datapath #(.RESET_PC (RESET_PC)) core_datapath_inst
     (.clk        (clk),
      .i_reset    (i_reset),
      .i_seq      (seq),
      .i_ctrl     (ctrl),
      .i_imm_bit  (imm_bit),
      .i_rs1_bit  (rs1_bit),
      .i_rs2_bit  (rs2_bit),
      .i_dbus_rsp (dbus_rsp),
      .o_rd_bit   (rd_bit),
      .o_ibus_adr (ibus_adr),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_we  (dbus_we));

   bus_arbiter bus_arbiter_inst
     (.clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_req (ibus_req),
      .i_dbus_req (dbus_req),
      .o_ibus_rsp (ibus_rsp),
      .o_dbus_rsp (dbus_rsp),
      .o_mem_req  (o_mem_req),
      .i_mem_rsp  (i_mem_rsp));

endmodule

`default_nettype wire

/* testbench/cpu_props.sv */
`default_nettype none
`timescale 1ns/1ps

module cpu_props
   import bus_pkg::*;
  (
   input wire           clk,
   input wire           i_reset,
   input wire bus_req_t i_mem_req,
   input wire bus_rsp_t i_mem_rsp
   );

   no_cyc_in_reset: assert property (@(posedge clk) i_reset |=> !i_mem_req.cyc)
      else $error("bus cycle open during reset");

   // Master holds its request until the ack
   req_stable: assert property (@(posedge clk) disable iff (i_reset)
      i_mem_req.cyc && !i_mem_rsp.ack |=> $stable(i_mem_req))
      else $error("bus request changed before ack");

   ack_with_cyc: assert property (@(posedge clk) disable iff (i_reset)
      i_mem_rsp.ack |-> i_mem_req.cyc)
      else $error("ack seen without an open cycle");

endmodule

bind cpu_top cpu_props cpu_props_inst
  (.clk       (clk),
   .i_reset   (i_reset),
   .i_mem_req (o_mem_req),
   .i_mem_rsp (i_mem_rsp));

`default_nettype wire

/* testbench/tb_cpu.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_cpu
   import bus_pkg::*;
  ;

   logic        clk;
   logic        reset;
   bus_req_t    mem_req;
   bus_rsp_t    mem_rsp;

   logic [31:0] mem [256];
   logic [7:0]  exp_kind [$];
   logic [31:0] exp_adr [$];
   logic [31:0] exp_dat [$];
   int          n_expected;
   int          n_done;

   logic [31:0] rng;
   logic        pending;
   logic [1:0]  wait_left;
   logic [7:0]  mem_idx;

   cpu_top #(.RESET_PC (32'd0)) cpu_top_inst
     (.clk       (clk),
      .i_reset   (reset),
      .o_mem_req (mem_req),
      .i_mem_rsp (mem_rsp));

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic report_failure();
      $display("TEST FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   // Next trace entry must match the acked request
   task automatic check_bus_req(input bus_req_t req);
      logic [7:0]  kind;
      logic [31:0] adr;
      logic [31:0] dat;
      if (exp_kind.size() != 0) begin
         kind = exp_kind.pop_front();
         adr  = exp_adr.pop_front();
         dat  = exp_dat.pop_front();
         if (req.adr !== adr) begin
            $display("Error: o_mem_req.adr = %h, expected %h", req.adr, adr);
            report_failure();
         end else if (req.we !== (kind == "S")) begin
            $display("Error: o_mem_req.we = %h, expected %h", req.we, kind == "S");
            report_failure();
         end else if (kind == "S" && req.dat !== dat) begin
            $display("Error: o_mem_req.dat = %h, expected %h", req.dat, dat);
            report_failure();
         end
      end
   endtask

   task automatic check_count(input int got, input int expected);
      if (got != expected) begin
         $display("Error: transaction count = %h, expected %h", got, expected);
         report_failure();
      end
   endtask

   // Memory model with 0 to 3 cycles of ack delay
   always @(negedge clk) begin
      if (reset) begin
         mem_rsp = '0;
         pending = 1'b0;
      end else if (mem_rsp.ack) begin
         mem_rsp.ack = 1'b0;
      end else if (mem_req.cyc === 1'b1) begin
         if (!pending) begin
            rng       = next_random(rng);
            wait_left = rng[1:0];
            pending   = 1'b1;
         end
         if (wait_left == 2'd0) begin
            check_bus_req(mem_req);
            mem_idx = mem_req.adr[9:2];
            if (mem_req.we)
               mem[mem_idx] = mem_req.dat;
            mem_rsp.rdt = mem[mem_idx];
            mem_rsp.ack = 1'b1;
            pending     = 1'b0;
            n_done      = n_done + 1;
         end else begin
            wait_left = wait_left - 2'd1;
         end
      end
   end

   initial begin
      int          fd;
      int          code;
      logic [7:0]  kind;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [7:0]  idx;
      string       line;
      reset      = 1'b1;
      mem_rsp    = '0;
      rng        = 32'h3a2b9ef0;
      pending    = 1'b0;
      wait_left  = 2'd0;
      n_done     = 0;
      n_expected = 0;
      for (int i = 0; i < 256; i++)
         mem[i] = 32'hc0de0000 ^ (32'(i) << 2);

      fd = $fopen("testbench/program_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open testbench/program_trace.txt");
         report_failure();
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, " %c", kind);
         if (code != 1)
            break;
         case (kind)
            "#": code = $fgets(line, fd);
            "M": begin
               code = $fscanf(fd, " %h", adr);
               for (int k = 0; k < 4; k++) begin
                  code = $fscanf(fd, " %h", dat);
                  idx  = adr[9:2] + 8'(k);
                  mem[idx] = dat;
               end
            end
            "F", "L", "S": begin
               code = $fscanf(fd, " %h", adr);
               dat  = 32'd0;
               if (kind == "S")
                  code = $fscanf(fd, " %h", dat);
               exp_kind.push_back(kind);
               exp_adr.push_back(adr);
               exp_dat.push_back(dat);
            end
            default: begin
               $display("Unknown record in the trace file");
               report_failure();
            end
         endcase
      end
      $fclose(fd);
      n_expected = exp_kind.size();

      // No bus cycle may start while reset is held
      repeat (16) begin
         @(negedge clk);
         if (mem_req.cyc === 1'b1) begin
            $display("A bus cycle started during reset");
            report_failure();
         end
      end
      reset = 1'b0;

      while (n_done < n_expected)
         @(posedge clk);
      // Next request cannot be acked within 33 cycles of the last ack
      repeat (33) @(posedge clk);
      check_count(n_done, n_expected);
      $display("TEST OK");
      $finish;
   end

   // Watchdog scaled to the trace length
   initial begin
      wait (n_expected != 0);
      repeat (200 * n_expected + 16) @(posedge clk);
      $display("Timeout with %0d of %0d bus transactions done", n_done, n_expected);
      report_failure();
   end

endmodule

`default_nettype wire

/* testbench/program_trace.txt */
# M adr w0 w1 w2 w3 preloads four words from adr, F adr is a fetch, L adr a load
# S adr dat is a store, all values hex, transactions listed in bus order
M 00000000 123450B7 6780E113 0F017193 00314233
M 00000010 403202B3 10502023 10402303 005303B3
M 00000020 0023F433 003464B3 FFF4C513 10A02423
M 00000030 00500593 00058463 00059463 10B02823
M 00000040 00B58463 10B02823 0000000B 00C0066F
M 00000050 10B02823 10B02823 10C02623 0000006F
M 00000104 00001000 00000000 00000000 00000000
F 00000000 F 00000004 F 00000008 F 0000000C F 00000010 F 00000014
S 00000100 12345598 F 00000018 L 00000104 F 0000001C F 00000020
F 00000024 F 00000028 F 0000002C S 00000108 EDCBBB87 F 00000030
F 00000034 F 00000038 F 00000040 F 00000048 F 0000004C F 00000058
S 0000010C 00000050 F 0000005C F 0000005C

/* compile.f */
common/rv_isa_pkg.sv
common/bus_pkg.sv
core/core_state.sv
core/core_decode.sv
core/serial_rf.sv
core/core_datapath.sv
logic/bus_arbiter.sv
logic/cpu_top.sv
testbench/cpu_props.sv
testbench/tb_cpu.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f compile.f -o Vtb_cpu

run: compile
	./obj_dir/Vtb_cpu > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
